//--- hdl/dz_cfg.svh
`ifndef DZ_CFG_SVH
`define DZ_CFG_SVH

// ==================================================
// scan and countdown timing
// ==================================================

// clocks each row stays lit
`define DZ_SCAN_DIV 4

// rows per frame, fixed by the 8x8 matrix
`define DZ_ROWS 8

// one full frame
`define DZ_FRAME_CLKS (`DZ_ROWS * `DZ_SCAN_DIV)

// clocks per countdown step
// keep it a whole number of frames
`define DZ_TICK_DIV 256

// digit loaded by start
`define DZ_MAX_DIGIT 5

`endif

//--- hdl/matrix_pkg.sv
`default_nettype none

package matrix_pkg;

    // ==================================================
    // matrix geometry
    // ==================================================

    typedef logic [2:0] row_idx_t;  // active row number
    typedef logic [7:0] line_t;     // one row or column vector

    localparam line_t LINE_OFF = 8'b0000_0000;

    // scanner output, index and its decoded row line
    typedef struct packed {
        row_idx_t row_idx;
        line_t    row_onehot;
    } scan_t;

    // ==================================================
    // helpers
    // ==================================================

    // row number to row select line
    function automatic line_t row_decode(input row_idx_t idx);
        line_t sel;
        sel = line_t'(1) << idx;
        return sel;
    endfunction

    // next row, 7 wraps to 0
    function automatic row_idx_t row_step(input row_idx_t idx);
        row_idx_t nxt;
        nxt = idx + 3'd1;
        return nxt;
    endfunction

endpackage

`default_nettype wire

//--- hdl/count_pkg.sv
`default_nettype none

package count_pkg;

    typedef logic [2:0] digit_t;    // 0 to 5 only

    typedef enum logic [1:0] {
        COLOR_RED    = 2'd0,
        COLOR_GREEN  = 2'd1,
        COLOR_YELLOW = 2'd2
    } color_e;

    typedef enum logic [1:0] {
        T_IDLE  = 2'd0,
        T_RUN   = 2'd1,
        T_PAUSE = 2'd2,
        T_DONE  = 2'd3
    } timer_state_e;

    typedef struct packed {
        digit_t digit;
        color_e color;
        logic   shown;  // set by first start
    } count_t;

    // ==================================================
    // color sequence r -> g -> y -> r
    // ==================================================
    function automatic color_e color_step(input color_e c);
        case (c)
            COLOR_RED:   return COLOR_GREEN;
            COLOR_GREEN: return COLOR_YELLOW;
            default:     return COLOR_RED;
        endcase
    endfunction

    // yellow lights both dies
    function automatic logic color_red_on(input color_e c);
        return c != COLOR_GREEN;
    endfunction

    function automatic logic color_green_on(input color_e c);
        return c != COLOR_RED;
    endfunction

endpackage

`default_nettype wire

//--- hdl/row_scanner.sv
`timescale 1ns/1ps
`default_nettype none

`include "dz_cfg.svh"

module row_scanner (
    input  logic               clk,
    input  logic               rst,
    output matrix_pkg::scan_t  scan
);

    import matrix_pkg::*;

    localparam int DIV_W = (`DZ_SCAN_DIV > 1) ? $clog2(`DZ_SCAN_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`DZ_SCAN_DIV - 1);

    logic [DIV_W-1:0] div_cnt;
    row_idx_t         next_idx;

    assign next_idx = row_step(scan.row_idx);

    // ==================================================
    // row divider and index
    // ==================================================
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt         <= '0;
            scan.row_idx    <= '0;
            scan.row_onehot <= row_decode('0);
        end
        else if (div_cnt == DIV_LAST)
        begin
            div_cnt         <= '0;
            scan.row_idx    <= next_idx;
            scan.row_onehot <= row_decode(next_idx);  // decoded alongside index
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // select line must agree with the index the mixer uses for the ROM
    a_row_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot(scan.row_onehot) && scan.row_onehot[scan.row_idx]
    );

endmodule

`default_nettype wire

//--- hdl/countdown_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "dz_cfg.svh"

module countdown_timer (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic              pause,
    output count_pkg::count_t count
);

    import count_pkg::*;

    localparam int TICK_W = (`DZ_TICK_DIV > 1) ? $clog2(`DZ_TICK_DIV) : 1;
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`DZ_TICK_DIV - 1);

    // each digit has to fill whole frames
    if ((`DZ_TICK_DIV % `DZ_FRAME_CLKS) != 0)
    begin : g_bad_tick_div
        $error("DZ_TICK_DIV is not a multiple of the frame length");
    end

    timer_state_e      state;
    logic [TICK_W-1:0] tick_cnt;
    logic              tick_done;
    digit_t            digit;
    color_e            run_color;     // color of the current run
    color_e            queued_color;  // color for the next start
    logic              shown;

    assign tick_done = (tick_cnt == TICK_LAST);

    // ==================================================
    // timer FSM
    // ==================================================
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state        <= T_IDLE;
            tick_cnt     <= '0;
            digit        <= '0;
            run_color    <= COLOR_RED;
            queued_color <= COLOR_RED;
            shown        <= 1'b0;
        end
        else if (start)
        begin
            // restart from any state
            state     <= T_RUN;
            tick_cnt  <= '0;
            digit     <= digit_t'(`DZ_MAX_DIGIT);
            run_color <= queued_color;  // unchanged if no run finished
            shown     <= 1'b1;
        end
        else
        begin
            case (state)
                T_RUN:
                begin
                    if (pause)
                    begin
                        state <= T_PAUSE;  // tick count held
                    end
                    else if (tick_done)
                    begin
                        tick_cnt <= '0;
                        digit    <= digit - 3'd1;
                        if (digit == 3'd1)
                        begin
                            state        <= T_DONE;
                            queued_color <= color_step(run_color);
                        end
                    end
                    else
                    begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                T_PAUSE:
                begin
                    if (!pause)
                        state <= T_RUN;
                end
                default:
                    ;  // idle and done wait for start
            endcase
        end
    end

    assign count = '{digit: digit, color: run_color, shown: shown};

    a_digit_range: assert property (
        @(posedge clk) disable iff (rst)
        digit <= digit_t'(`DZ_MAX_DIGIT)
    );

endmodule

`default_nettype wire

//--- hdl/glyph_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module glyph_mixer (
    input  logic               clk,
    input  logic               rst,
    input  matrix_pkg::scan_t  scan,
    input  count_pkg::count_t  count,
    output matrix_pkg::line_t  row,
    output matrix_pkg::line_t  colr,
    output matrix_pkg::line_t  colg
);

    import matrix_pkg::*;
    import count_pkg::*;

    line_t glyph;
    logic  red_en;
    logic  grn_en;
    logic  shown_q;

    // ==================================================
    // glyph ROM, key is {digit, row} in octal
    // ==================================================
    always_comb
    begin
        case ({count.digit, scan.row_idx})
            // 0
            6'o01: glyph = 8'b0011_1100;
            6'o02, 6'o03,
            6'o04, 6'o05,
            6'o06: glyph = 8'b0110_0110;
            6'o07: glyph = 8'b0011_1100;
            // 1
            6'o11: glyph = 8'b0001_1000;
            6'o12: glyph = 8'b0011_1000;
            6'o13, 6'o14,
            6'o15, 6'o16: glyph = 8'b0001_1000;
            6'o17: glyph = 8'b0111_1110;
            // 2
            6'o21: glyph = 8'b0011_1100;
            6'o22: glyph = 8'b0110_0110;
            6'o23: glyph = 8'b0000_0110;
            6'o24: glyph = 8'b0000_1100;
            6'o25: glyph = 8'b0001_1000;
            6'o26: glyph = 8'b0011_0000;
            6'o27: glyph = 8'b0111_1110;
            // 3
            6'o31: glyph = 8'b0011_1100;
            6'o32: glyph = 8'b0110_0110;
            6'o33: glyph = 8'b0000_0110;
            6'o34: glyph = 8'b0001_1100;
            6'o35: glyph = 8'b0000_0110;
            6'o36, 6'o37: glyph = 8'b0000_1100;
            // 4
            6'o41: glyph = 8'b0000_1100;
            6'o42: glyph = 8'b0001_1100;
            6'o43: glyph = 8'b0010_1100;
            6'o44: glyph = 8'b0100_1100;
            6'o45: glyph = 8'b0111_1110;
            6'o46, 6'o47: glyph = 8'b0000_1100;
            // 5
            6'o51: glyph = 8'b0111_1110;
            6'o52: glyph = 8'b0110_0000;
            6'o53: glyph = 8'b0111_1100;
            6'o54, 6'o55: glyph = 8'b0000_0110;
            6'o56: glyph = 8'b0110_0110;
            6'o57: glyph = 8'b0011_1100;
            default: glyph = LINE_OFF;  // row 0 and unused digits
        endcase
    end

    // blank until the first start
    assign red_en = count.shown && color_red_on(count.color);
    assign grn_en = count.shown && color_green_on(count.color);

    // ==================================================
    // output registers
    // ==================================================
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row     <= LINE_OFF;
            colr    <= LINE_OFF;
            colg    <= LINE_OFF;
            shown_q <= 1'b0;
        end
        else
        begin
            row     <= scan.row_onehot;  // scans even when blank
            colr    <= red_en ? glyph : LINE_OFF;
            colg    <= grn_en ? glyph : LINE_OFF;
            shown_q <= count.shown;
        end
    end

    a_blank_unshown: assert property (
        @(posedge clk) disable iff (rst)
        !shown_q |-> (colr == LINE_OFF && colg == LINE_OFF)
    );

endmodule

`default_nettype wire

//--- hdl/dz_display_top.sv
`timescale 1ns/1ps
`default_nettype none

module dz_display_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic              pause,
    output matrix_pkg::line_t row,
    output matrix_pkg::line_t colr,
    output matrix_pkg::line_t colg
);

    import matrix_pkg::*;
    import count_pkg::*;

    scan_t  scan_w;   // active row
    count_t count_w;  // digit, color, shown

    // ==================================================
    // scan and count side by side
    // ==================================================
    row_scanner u_scanner (
        .clk  (clk),
        .rst  (rst),
        .scan (scan_w)
    );

    countdown_timer u_timer (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .pause (pause),
        .count (count_w)
    );

    // one more register stage, start to glyph is two clocks
    glyph_mixer u_mixer (
        .clk   (clk),
        .rst   (rst),
        .scan  (scan_w),
        .count (count_w),
        .row   (row),
        .colr  (colr),
        .colg  (colg)
    );

endmodule

`default_nettype wire

//--- testbench/tb_dz_display.sv
`timescale 1ns/1ps
`default_nettype none

`include "dz_cfg.svh"

module tb_dz_display;

    import matrix_pkg::*;
    import count_pkg::*;

    localparam int FRAME   = `DZ_FRAME_CLKS;
    localparam int WAIT_TO = 3 * FRAME;  // clocks allowed to find a frame start

    typedef enum logic [1:0] {
        ACT_WAIT    = 2'd0,
        ACT_START   = 2'd1,
        ACT_PAUSE   = 2'd2,
        ACT_RELEASE = 2'd3
    } act_e;

    typedef struct packed {
        act_e       act;
        logic [7:0] frames;  // frame starts passed before the check
        digit_t     digit;
        color_e     color;
        logic       shown;
    } step_t;

    logic  clk;
    logic  rst;
    logic  start;
    logic  pause;
    line_t row;
    line_t colr;
    line_t colg;

    step_t steps[$];
    int    errors;
    int    passed;
    int    failed;
    bit    timed_out;

    dz_display_top dut0 (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .pause (pause),
        .row   (row),
        .colr  (colr),
        .colg  (colg)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ==================================================
    // reference models
    // ==================================================

    // font for 0 to 5, top byte is row 0
    function automatic line_t glyph_row(input digit_t d, input row_idx_t r);
        logic [63:0] g;
        case (d)
            3'd0: g = 64'h00_3C_66_66_66_66_66_3C;
            3'd1: g = 64'h00_18_38_18_18_18_18_7E;
            3'd2: g = 64'h00_3C_66_06_0C_18_30_7E;
            3'd3: g = 64'h00_3C_66_06_1C_06_0C_0C;
            3'd4: g = 64'h00_0C_1C_2C_4C_7E_0C_0C;
            3'd5: g = 64'h00_7E_60_7C_06_06_66_3C;
            default: g = '0;
        endcase
        return g[63 - 8 * int'(r) -: 8];
    endfunction

    function automatic bit red_lit(input color_e c);
        return (c == COLOR_RED) || (c == COLOR_YELLOW);
    endfunction

    function automatic bit green_lit(input color_e c);
        return (c == COLOR_GREEN) || (c == COLOR_YELLOW);
    endfunction

    function automatic string act_name(input act_e a);
        case (a)
            ACT_START:   return "start";
            ACT_PAUSE:   return "pause";
            ACT_RELEASE: return "release";
            default:     return "wait";
        endcase
    endfunction

    function automatic void add_step(input act_e a, input int frames, input int d,
                                     input color_e c, input bit shown);
        step_t st;
        st.act    = a;
        st.frames = 8'(frames);
        st.digit  = digit_t'(d);
        st.color  = c;
        st.shown  = shown;
        steps.push_back(st);
    endfunction

    // ==================================================
    // stimulus table
    // ==================================================
    // one digit lasts 8 frames, so a check 8 frames later sees the next digit
    function automatic void build_table();
        add_step(ACT_WAIT, 1, 0, COLOR_RED, 1'b0);  // dark before any start
        add_step(ACT_START, 1, 5, COLOR_RED, 1'b1);
        add_step(ACT_WAIT, 8, 4, COLOR_RED, 1'b1);
        add_step(ACT_WAIT, 8, 3, COLOR_RED, 1'b1);
        add_step(ACT_PAUSE, 1, 3, COLOR_RED, 1'b1);
        add_step(ACT_WAIT, 8, 3, COLOR_RED, 1'b1);  // frozen over two ticks
        add_step(ACT_WAIT, 8, 3, COLOR_RED, 1'b1);
        add_step(ACT_RELEASE, 1, 3, COLOR_RED, 1'b1);
        add_step(ACT_WAIT, 8, 2, COLOR_RED, 1'b1);
        add_step(ACT_WAIT, 8, 1, COLOR_RED, 1'b1);
        add_step(ACT_WAIT, 8, 0, COLOR_RED, 1'b1);
        add_step(ACT_WAIT, 8, 0, COLOR_RED, 1'b1);  // 0 holds
        // second run
        add_step(ACT_START, 1, 5, COLOR_GREEN, 1'b1);
        add_step(ACT_WAIT, 8, 4, COLOR_GREEN, 1'b1);
        add_step(ACT_WAIT, 8, 3, COLOR_GREEN, 1'b1);
        add_step(ACT_WAIT, 8, 2, COLOR_GREEN, 1'b1);
        add_step(ACT_WAIT, 8, 1, COLOR_GREEN, 1'b1);
        add_step(ACT_WAIT, 8, 0, COLOR_GREEN, 1'b1);
        // third run, restarted on digit 4
        add_step(ACT_START, 1, 5, COLOR_YELLOW, 1'b1);
        add_step(ACT_WAIT, 8, 4, COLOR_YELLOW, 1'b1);
        add_step(ACT_START, 1, 5, COLOR_YELLOW, 1'b1);
        add_step(ACT_WAIT, 8, 4, COLOR_YELLOW, 1'b1);
        add_step(ACT_WAIT, 8, 3, COLOR_YELLOW, 1'b1);
        add_step(ACT_WAIT, 8, 2, COLOR_YELLOW, 1'b1);
        add_step(ACT_WAIT, 8, 1, COLOR_YELLOW, 1'b1);
        add_step(ACT_WAIT, 8, 0, COLOR_YELLOW, 1'b1);
        // wraps back to red
        add_step(ACT_START, 1, 5, COLOR_RED, 1'b1);
        add_step(ACT_WAIT, 40, 0, COLOR_RED, 1'b1);
    endfunction

    // ==================================================
    // drivers and checkers
    // ==================================================

    // returns at the first negedge of row 0
    task automatic wait_frame_start(output bit ok);
        line_t prev;
        int    n;
        ok   = 1'b0;
        prev = row;
        for (n = 0; n < WAIT_TO && !ok; n++)
        begin
            @(negedge clk);
            ok   = (row == 8'h01) && (prev == 8'h80);
            prev = row;
        end
        if (!ok)
            $display("timeout at %0t: no frame start within %0d clocks", $time, WAIT_TO);
    endtask

    task automatic do_action(input act_e a, output bit ok);
        ok = 1'b1;
        if (a != ACT_WAIT)
        begin
            wait_frame_start(ok);
            if (ok)
            begin
                @(posedge clk);
                case (a)
                    ACT_START: start <= 1'b1;
                    ACT_PAUSE: pause <= 1'b1;
                    default:   pause <= 1'b0;
                endcase
                @(posedge clk);
                start <= 1'b0;  // single clock pulse
                @(negedge clk);
            end
        end
    endtask

    task automatic check_frame(input step_t s);
        line_t    seen;
        line_t    exp_r;
        line_t    exp_g;
        row_idx_t idx;
        int       i;
        int       b;
        seen = '0;
        for (i = 0; i < FRAME; i++)
        begin
            if (i > 0)
                @(negedge clk);
            idx = '0;
            for (b = 0; b < 8; b++)
            begin
                if (row[b])
                    idx = row_idx_t'(b);
            end
            assert ($onehot(row))
            else
            begin
                $display("error %0t: row 0x%02h is not one-hot", $time, row);
                errors++;
            end
            seen  = seen | row;
            exp_r = (s.shown && red_lit(s.color)) ? glyph_row(s.digit, idx) : '0;
            exp_g = (s.shown && green_lit(s.color)) ? glyph_row(s.digit, idx) : '0;
            assert (colr == exp_r && colg == exp_g)
            else
            begin
                $display("error %0t: row %0d colr 0x%02h colg 0x%02h, expected 0x%02h 0x%02h",
                         $time, idx, colr, colg, exp_r, exp_g);
                errors++;
            end
        end
        assert (seen == 8'hFF)
        else
        begin
            $display("error %0t: rows seen 0x%02h, not all eight", $time, seen);
            errors++;
        end
    endtask

    task automatic print_result(input int num, input string what, input bit bad);
        if (bad)
            failed++;
        else
            passed++;
        $display("test %0d %s: %s", num, what, bad ? "FAIL" : "ok");
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial
    begin
        int    n;
        int    k;
        int    err_before;
        bit    ok;
        step_t s;
        rst       = 1'b1;
        start     = 1'b0;
        pause     = 1'b0;
        errors    = 0;
        passed    = 0;
        failed    = 0;
        timed_out = 1'b0;
        build_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (row == '0 && colr == '0 && colg == '0)
        else
        begin
            $display("error %0t: outputs not zero after reset", $time);
            errors++;
        end
        print_result(0, "reset", errors != 0);
        for (n = 0; n < steps.size() && !timed_out; n++)
        begin
            s          = steps[n];
            err_before = errors;
            do_action(s.act, ok);
            for (k = 0; k < int'(s.frames) && ok; k++)
                wait_frame_start(ok);
            if (ok)
                check_frame(s);
            else
                timed_out = 1'b1;
            print_result(n + 1, $sformatf("%s digit %0d %s shown %0d", act_name(s.act),
                         s.digit, s.color.name(), s.shown), !ok || errors != err_before);
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 passed + failed, passed, failed, errors);
        if (errors == 0 && failed == 0 && !timed_out)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+hdl
hdl/matrix_pkg.sv
hdl/count_pkg.sv
hdl/row_scanner.sv
hdl/countdown_timer.sv
hdl/glyph_mixer.sv
hdl/dz_display_top.sv
testbench/tb_dz_display.sv

//--- Makefile
# Verilator build and run of the dot matrix countdown testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_dz_display
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Verification passed" $(LOG); then \
		echo "simulation PASS"; \
	else \
		echo "simulation FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
